/* common/rs_defines.svh */
// Reservation station sizing and op-class codes
// Shared by the RTL and the testbench
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Station and core sizes
////////////////////////////////////////////////////////////////////////////

`define RS_SIZE    8   // Station entries
`define PRF_SIZE   64  // Physical registers
`define ROB_SIZE   32  // Reorder buffer slots
`define DATA_WIDTH 64  // Operand width

////////////////////////////////////////////////////////////////////////////
// Op classes, taken from op type bits [5:3]
////////////////////////////////////////////////////////////////////////////

`define OPCLASS_INT   3'h2  // Op type 0x10
`define OPCLASS_LOAD  3'h4  // Op type 0x20
`define OPCLASS_STORE 3'h5  // Op type 0x28

`endif

/* common/rs_pkg.sv */
// Reservation station types
// Width typedefs and the code enums used by the station and its testbench
`default_nettype none

`include "rs_defines.svh"

package rs_pkg;

	typedef logic [`DATA_WIDTH-1:0]        word_t;       // One operand
	typedef logic [$clog2(`PRF_SIZE)-1:0]  phys_tag_t;   // Physical register tag
	typedef logic [$clog2(`ROB_SIZE)-1:0]  rob_idx_t;    // Reorder buffer index
	typedef logic [5:0]                    op_type_t;    // Decoder op type
	typedef logic [`RS_SIZE-1:0]           entry_mask_t; // One bit per entry

	// ALU functions from the decoder
	typedef enum logic [4:0] {
		ALU_ADDQ    = 5'h00,
		ALU_SUBQ    = 5'h01,
		ALU_AND     = 5'h02,
		ALU_MULQ    = 5'h03,
		ALU_DEFAULT = 5'h1f  // Idle issue port
	} alu_func_t;

	// Unit class of an instruction
	typedef enum logic [1:0] {
		USE_ADDER      = 2'd0,
		USE_MULTIPLIER = 2'd1,
		USE_MEMORY     = 2'd2
	} fu_select_t;

	// Free entry report to rename
	typedef enum logic [1:0] {
		RS_NO_ENTRY_EMPTY          = 2'd0,
		RS_ONE_ENTRY_EMPTY         = 2'd1,
		RS_TWO_OR_MORE_ENTRY_EMPTY = 2'd2
	} rs_full_t;

endpackage

`default_nettype wire

/* rs/rs_dispatch.sv */
// Reservation station dispatch
// Decodes the unit class, forwards a same-cycle result broadcast into the
// operands, grants the lowest free entry and reports how many are free
`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module rs_dispatch (
	input  logic                load,
	input  rs_pkg::op_type_t    op_type,
	input  rs_pkg::alu_func_t   alu_func,
	input  rs_pkg::word_t       opa,
	input  rs_pkg::word_t       opb,
	input  logic                opa_valid,
	input  logic                opb_valid,
	input  rs_pkg::word_t       cdb_data,
	input  rs_pkg::phys_tag_t   cdb_tag,
	input  logic                cdb_valid,
	input  rs_pkg::entry_mask_t entry_busy,
	output rs_pkg::entry_mask_t entry_load,
	output rs_pkg::fu_select_t  fu_select,
	output rs_pkg::word_t       opa_fwd,
	output rs_pkg::word_t       opb_fwd,
	output logic                opa_fwd_valid,
	output logic                opb_fwd_valid,
	output rs_pkg::rs_full_t    rs_full
);
	import rs_pkg::*;

	logic [2:0]                op_class;
	phys_tag_t                 opa_tag;
	phys_tag_t                 opb_tag;
	logic [$clog2(`RS_SIZE):0] free_count;

	assign op_class = op_type[5:3];
	assign opa_tag  = opa[$bits(phys_tag_t)-1:0];  // Tag sits in the low bits
	assign opb_tag  = opb[$bits(phys_tag_t)-1:0];

	always_comb begin
		if (op_class == `OPCLASS_INT && alu_func == ALU_MULQ) begin
			fu_select = USE_MULTIPLIER;
		end else if (op_class == `OPCLASS_LOAD || op_class == `OPCLASS_STORE) begin
			fu_select = USE_MEMORY;
		end else begin
			fu_select = USE_ADDER;
		end
	end

	// Result broadcast in the dispatch cycle
	always_comb begin
		opa_fwd       = opa;
		opa_fwd_valid = opa_valid;
		opb_fwd       = opb;
		opb_fwd_valid = opb_valid;
		if (!opa_valid && cdb_valid && cdb_tag == opa_tag) begin
			opa_fwd       = cdb_data;
			opa_fwd_valid = 1'b1;
		end
		if (!opb_valid && cdb_valid && cdb_tag == opb_tag) begin
			opb_fwd       = cdb_data;
			opb_fwd_valid = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Entry allocation and free count
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		entry_load = '0;
		free_count = '0;
		for (int i = `RS_SIZE-1; i >= 0; i--) begin  // Last hit is the lowest index
			if (!entry_busy[i]) begin
				entry_load    = '0;
				entry_load[i] = load;
				free_count    = free_count + 1;
			end
		end
	end

	always_comb begin
		if (free_count >= 2) begin
			rs_full = RS_TWO_OR_MORE_ENTRY_EMPTY;
		end else if (free_count == 1) begin
			rs_full = RS_ONE_ENTRY_EMPTY;
		end else begin
			rs_full = RS_NO_ENTRY_EMPTY;
		end
	end

	// At most one entry loads, and never one still holding an instruction
	always_comb begin
		assert final ($onehot0(entry_load) && (entry_load & entry_busy) == '0)
			else $error("dispatch grant 0x%h overlaps busy 0x%h", entry_load, entry_busy);
	end

endmodule

`default_nettype wire

/* rs/rs_entry.sv */
// Reservation station entry
// Holds one instruction, wakes its operands from the result bus and
// reports busy and ready to the issue logic
`timescale 1ns/1ps
`default_nettype none

module rs_entry (
	input  logic               clock,
	input  logic               reset,
	input  logic               load,
	input  logic               free,
	input  rs_pkg::phys_tag_t  dest_tag_in,
	input  rs_pkg::rob_idx_t   rob_idx_in,
	input  rs_pkg::op_type_t   op_type_in,
	input  rs_pkg::alu_func_t  alu_func_in,
	input  rs_pkg::fu_select_t fu_select_in,
	input  rs_pkg::word_t      opa_in,
	input  rs_pkg::word_t      opb_in,
	input  logic               opa_valid_in,
	input  logic               opb_valid_in,
	input  rs_pkg::word_t      cdb_data,
	input  rs_pkg::phys_tag_t  cdb_tag,
	input  logic               cdb_valid,
	output logic               busy,
	output logic               ready,
	output rs_pkg::word_t      opa,
	output rs_pkg::word_t      opb,
	output rs_pkg::phys_tag_t  dest_tag,
	output rs_pkg::rob_idx_t   rob_idx,
	output rs_pkg::op_type_t   op_type,
	output rs_pkg::alu_func_t  alu_func,
	output rs_pkg::fu_select_t fu_select
);
	import rs_pkg::*;

	logic      opa_valid;
	logic      opb_valid;
	phys_tag_t opa_tag;
	phys_tag_t opb_tag;
	logic      opa_wake;
	logic      opb_wake;

	assign opa_tag  = opa[$bits(phys_tag_t)-1:0];  // Waiting operand holds its tag
	assign opb_tag  = opb[$bits(phys_tag_t)-1:0];
	assign opa_wake = busy && !opa_valid && cdb_valid && cdb_tag == opa_tag;
	assign opb_wake = busy && !opb_valid && cdb_valid && cdb_tag == opb_tag;

	assign ready = busy && opa_valid && opb_valid;

	////////////////////////////////////////////////////////////////////////////
	// Occupancy and operand state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy      <= 1'b0;
			opa_valid <= 1'b0;
			opb_valid <= 1'b0;
		end else if (load) begin
			busy      <= 1'b1;
			opa_valid <= opa_valid_in;
			opb_valid <= opb_valid_in;
		end else begin
			if (free) begin
				busy <= 1'b0;  // Issued this cycle
			end
			if (opa_wake) begin
				opa_valid <= 1'b1;
			end
			if (opb_wake) begin
				opb_valid <= 1'b1;
			end
		end
	end

	// Instruction fields and operand data
	always_ff @(posedge clock) begin
		if (load) begin
			opa       <= opa_in;
			opb       <= opb_in;
			dest_tag  <= dest_tag_in;
			rob_idx   <= rob_idx_in;
			op_type   <= op_type_in;
			alu_func  <= alu_func_in;
			fu_select <= fu_select_in;
		end else begin
			if (opa_wake) begin
				opa <= cdb_data;
			end
			if (opb_wake) begin
				opb <= cdb_data;
			end
		end
	end

	// Dispatch only targets an empty entry
	load_while_busy: assert property (@(posedge clock) disable iff (reset) load |-> !busy)
		else $error("entry loaded while still holding an instruction");

	// Issue only frees an entry whose operands are complete
	free_not_ready: assert property (@(posedge clock) disable iff (reset) free |-> ready)
		else $error("entry freed before it was ready");

endmodule

`default_nettype wire

/* rs/rs_issue_select.sv */
// Reservation station issue selection
// For each free unit, picks the lowest ready entry of its class, drives its
// fields to the unit and frees that entry
`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module rs_issue_select (
	input  logic                mult_available,
	input  logic                adder_available,
	input  logic                memory_available,
	input  rs_pkg::entry_mask_t entry_ready,
	input  rs_pkg::word_t       entry_opa       [`RS_SIZE-1:0],
	input  rs_pkg::word_t       entry_opb       [`RS_SIZE-1:0],
	input  rs_pkg::phys_tag_t   entry_dest_tag  [`RS_SIZE-1:0],
	input  rs_pkg::rob_idx_t    entry_rob_idx   [`RS_SIZE-1:0],
	input  rs_pkg::op_type_t    entry_op_type   [`RS_SIZE-1:0],
	input  rs_pkg::alu_func_t   entry_alu_func  [`RS_SIZE-1:0],
	input  rs_pkg::fu_select_t  entry_fu_select [`RS_SIZE-1:0],
	output rs_pkg::entry_mask_t entry_free,
	output rs_pkg::word_t       mult_opa,
	output rs_pkg::word_t       mult_opb,
	output rs_pkg::phys_tag_t   mult_dest_tag,
	output rs_pkg::rob_idx_t    mult_rob_idx,
	output rs_pkg::op_type_t    mult_op_type,
	output rs_pkg::alu_func_t   mult_alu_func,
	output logic                mult_valid,
	output rs_pkg::word_t       adder_opa,
	output rs_pkg::word_t       adder_opb,
	output rs_pkg::phys_tag_t   adder_dest_tag,
	output rs_pkg::rob_idx_t    adder_rob_idx,
	output rs_pkg::op_type_t    adder_op_type,
	output rs_pkg::alu_func_t   adder_alu_func,
	output logic                adder_valid,
	output rs_pkg::word_t       mem_opa,
	output rs_pkg::word_t       mem_opb,
	output rs_pkg::phys_tag_t   mem_dest_tag,
	output rs_pkg::rob_idx_t    mem_rob_idx,
	output rs_pkg::op_type_t    mem_op_type,
	output rs_pkg::alu_func_t   mem_alu_func,
	output logic                mem_valid
);
	import rs_pkg::*;

	// Unit 0 is the multiplier, 1 the adder, 2 memory
	localparam fu_select_t unit_class [3] = '{USE_MULTIPLIER, USE_ADDER, USE_MEMORY};

	logic [2:0]  unit_available;
	entry_mask_t grant        [3];
	word_t       sel_opa      [3];
	word_t       sel_opb      [3];
	phys_tag_t   sel_dest_tag [3];
	rob_idx_t    sel_rob_idx  [3];
	op_type_t    sel_op_type  [3];
	alu_func_t   sel_alu_func [3];

	assign unit_available = {memory_available, adder_available, mult_available};

	always_comb begin
		for (int u = 0; u < 3; u++) begin
			grant[u]        = '0;
			sel_opa[u]      = '0;
			sel_opb[u]      = '0;
			sel_dest_tag[u] = '0;
			sel_rob_idx[u]  = '0;
			sel_op_type[u]  = '0;
			sel_alu_func[u] = ALU_DEFAULT;  // Idle port
			for (int i = `RS_SIZE-1; i >= 0; i--) begin  // Lowest match wins
				if (unit_available[u] && entry_ready[i] &&
				    entry_fu_select[i] == unit_class[u]) begin
					grant[u]        = '0;
					grant[u][i]     = 1'b1;
					sel_opa[u]      = entry_opa[i];
					sel_opb[u]      = entry_opb[i];
					sel_dest_tag[u] = entry_dest_tag[i];
					sel_rob_idx[u]  = entry_rob_idx[i];
					sel_op_type[u]  = entry_op_type[i];
					sel_alu_func[u] = entry_alu_func[i];
				end
			end
		end
	end

	assign entry_free = grant[0] | grant[1] | grant[2];

	////////////////////////////////////////////////////////////////////////////
	// Unit ports
	////////////////////////////////////////////////////////////////////////////

	assign mult_opa       = sel_opa[0];
	assign mult_opb       = sel_opb[0];
	assign mult_dest_tag  = sel_dest_tag[0];
	assign mult_rob_idx   = sel_rob_idx[0];
	assign mult_op_type   = sel_op_type[0];
	assign mult_alu_func  = sel_alu_func[0];
	assign mult_valid     = |grant[0];

	assign adder_opa      = sel_opa[1];
	assign adder_opb      = sel_opb[1];
	assign adder_dest_tag = sel_dest_tag[1];
	assign adder_rob_idx  = sel_rob_idx[1];
	assign adder_op_type  = sel_op_type[1];
	assign adder_alu_func = sel_alu_func[1];
	assign adder_valid    = |grant[1];

	assign mem_opa        = sel_opa[2];
	assign mem_opb        = sel_opb[2];
	assign mem_dest_tag   = sel_dest_tag[2];
	assign mem_rob_idx    = sel_rob_idx[2];
	assign mem_op_type    = sel_op_type[2];
	assign mem_alu_func   = sel_alu_func[2];
	assign mem_valid      = |grant[2];

	// Class decoded at dispatch keeps the units apart
	always_comb begin
		assert final ((grant[0] & grant[1]) == '0 && (grant[0] & grant[2]) == '0 &&
		              (grant[1] & grant[2]) == '0)
			else $error("one entry granted to two units");
	end

endmodule

`default_nettype wire

/* rs/rs.sv */
// Reservation station top level
// Eight entries fed by one dispatch port and one result bus, issuing to a
// multiplier, an adder and a memory unit
`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module rs (
	input  logic               clock,
	input  logic               reset,
	// Dispatch from rename
	input  logic               load,
	input  rs_pkg::phys_tag_t  dest_tag,
	input  rs_pkg::word_t      opa,
	input  logic               opa_valid,
	input  rs_pkg::word_t      opb,
	input  logic               opb_valid,
	input  rs_pkg::op_type_t   op_type,
	input  rs_pkg::alu_func_t  alu_func,
	input  rs_pkg::rob_idx_t   rob_idx,
	// Result bus
	input  rs_pkg::word_t      cdb_data,
	input  rs_pkg::phys_tag_t  cdb_tag,
	input  logic               cdb_valid,
	// Unit status
	input  logic               mult_available,
	input  logic               adder_available,
	input  logic               memory_available,
	// Multiplier issue
	output rs_pkg::word_t      mult_opa,
	output rs_pkg::word_t      mult_opb,
	output rs_pkg::phys_tag_t  mult_dest_tag,
	output rs_pkg::rob_idx_t   mult_rob_idx,
	output rs_pkg::op_type_t   mult_op_type,
	output rs_pkg::alu_func_t  mult_alu_func,
	output logic               mult_valid,
	// Adder issue
	output rs_pkg::word_t      adder_opa,
	output rs_pkg::word_t      adder_opb,
	output rs_pkg::phys_tag_t  adder_dest_tag,
	output rs_pkg::rob_idx_t   adder_rob_idx,
	output rs_pkg::op_type_t   adder_op_type,
	output rs_pkg::alu_func_t  adder_alu_func,
	output logic               adder_valid,
	// Memory issue
	output rs_pkg::word_t      mem_opa,
	output rs_pkg::word_t      mem_opb,
	output rs_pkg::phys_tag_t  mem_dest_tag,
	output rs_pkg::rob_idx_t   mem_rob_idx,
	output rs_pkg::op_type_t   mem_op_type,
	output rs_pkg::alu_func_t  mem_alu_func,
	output logic               mem_valid,
	output rs_pkg::rs_full_t   rs_full
);
	import rs_pkg::*;

	entry_mask_t entry_load;
	entry_mask_t entry_busy;
	entry_mask_t entry_ready;
	entry_mask_t entry_free;
	fu_select_t  fu_select;
	word_t       opa_fwd;
	word_t       opb_fwd;
	logic        opa_fwd_valid;
	logic        opb_fwd_valid;

	// Per-entry fields toward issue
	word_t       entry_opa       [`RS_SIZE-1:0];
	word_t       entry_opb       [`RS_SIZE-1:0];
	phys_tag_t   entry_dest_tag  [`RS_SIZE-1:0];
	rob_idx_t    entry_rob_idx   [`RS_SIZE-1:0];
	op_type_t    entry_op_type   [`RS_SIZE-1:0];
	alu_func_t   entry_alu_func  [`RS_SIZE-1:0];
	fu_select_t  entry_fu_select [`RS_SIZE-1:0];

	rs_dispatch dispatch_inst (
		.load          (load),
		.op_type       (op_type),
		.alu_func      (alu_func),
		.opa           (opa),
		.opb           (opb),
		.opa_valid     (opa_valid),
		.opb_valid     (opb_valid),
		.cdb_data      (cdb_data),
		.cdb_tag       (cdb_tag),
		.cdb_valid     (cdb_valid),
		.entry_busy    (entry_busy),
		.entry_load    (entry_load),
		.fu_select     (fu_select),
		.opa_fwd       (opa_fwd),
		.opb_fwd       (opb_fwd),
		.opa_fwd_valid (opa_fwd_valid),
		.opb_fwd_valid (opb_fwd_valid),
		.rs_full       (rs_full)
	);

	for (genvar i = 0; i < `RS_SIZE; i++) begin : g_entry
		rs_entry entry_inst (
			.clock        (clock),
			.reset        (reset),
			.load         (entry_load[i]),
			.free         (entry_free[i]),
			.dest_tag_in  (dest_tag),
			.rob_idx_in   (rob_idx),
			.op_type_in   (op_type),
			.alu_func_in  (alu_func),
			.fu_select_in (fu_select),
			.opa_in       (opa_fwd),
			.opb_in       (opb_fwd),
			.opa_valid_in (opa_fwd_valid),
			.opb_valid_in (opb_fwd_valid),
			.cdb_data     (cdb_data),
			.cdb_tag      (cdb_tag),
			.cdb_valid    (cdb_valid),
			.busy         (entry_busy[i]),
			.ready        (entry_ready[i]),
			.opa          (entry_opa[i]),
			.opb          (entry_opb[i]),
			.dest_tag     (entry_dest_tag[i]),
			.rob_idx      (entry_rob_idx[i]),
			.op_type      (entry_op_type[i]),
			.alu_func     (entry_alu_func[i]),
			.fu_select    (entry_fu_select[i])
		);
	end

	rs_issue_select select_inst (
		.mult_available   (mult_available),
		.adder_available  (adder_available),
		.memory_available (memory_available),
		.entry_ready      (entry_ready),
		.entry_opa        (entry_opa),
		.entry_opb        (entry_opb),
		.entry_dest_tag   (entry_dest_tag),
		.entry_rob_idx    (entry_rob_idx),
		.entry_op_type    (entry_op_type),
		.entry_alu_func   (entry_alu_func),
		.entry_fu_select  (entry_fu_select),
		.entry_free       (entry_free),
		.mult_opa         (mult_opa),
		.mult_opb         (mult_opb),
		.mult_dest_tag    (mult_dest_tag),
		.mult_rob_idx     (mult_rob_idx),
		.mult_op_type     (mult_op_type),
		.mult_alu_func    (mult_alu_func),
		.mult_valid       (mult_valid),
		.adder_opa        (adder_opa),
		.adder_opb        (adder_opb),
		.adder_dest_tag   (adder_dest_tag),
		.adder_rob_idx    (adder_rob_idx),
		.adder_op_type    (adder_op_type),
		.adder_alu_func   (adder_alu_func),
		.adder_valid      (adder_valid),
		.mem_opa          (mem_opa),
		.mem_opb          (mem_opb),
		.mem_dest_tag     (mem_dest_tag),
		.mem_rob_idx      (mem_rob_idx),
		.mem_op_type      (mem_op_type),
		.mem_alu_func     (mem_alu_func),
		.mem_valid        (mem_valid)
	);

endmodule

`default_nettype wire

/* sim/rs_tb.sv */
// Reservation station testbench
// Applies a table of dispatch, result-bus and unit-status rows, one per
// cycle, and checks the three issue ports and the free-entry report
`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module rs_tb;
	import rs_pkg::*;

	localparam int       HALF_PERIOD  = 20;
	localparam int       SAMPLE_DELAY = HALF_PERIOD - 1;  // Just before the rising edge
	localparam int       MAX_ROWS     = 48;
	localparam int       IDLE_LIMIT   = 20;               // Cycles allowed for the final drain
	localparam op_type_t OP_INT       = {`OPCLASS_INT, 3'd0};
	localparam op_type_t OP_LOAD      = {`OPCLASS_LOAD, 3'd0};
	localparam op_type_t OP_STORE     = {`OPCLASS_STORE, 3'd0};
	localparam op_type_t OP_BRANCH    = 6'h38;            // Neither integer nor memory
	localparam rs_full_t NO_FREE      = RS_NO_ENTRY_EMPTY;
	localparam rs_full_t ONE_FREE     = RS_ONE_ENTRY_EMPTY;
	localparam rs_full_t MANY_FREE    = RS_TWO_OR_MORE_ENTRY_EMPTY;
	localparam logic [2:0] ALL_UP     = 3'b111;           // {mem, adder, mult}
	localparam logic [2:0] ADDER_DOWN = 3'b101;

	// One issue port as seen by a unit
	typedef struct packed {
		logic      valid;
		word_t     opa;
		word_t     opb;
		phys_tag_t dest_tag;
		rob_idx_t  rob_idx;
		op_type_t  op_type;
		alu_func_t alu_func;
	} port_t;

	// One cycle of stimulus and the outputs expected in that cycle
	typedef struct packed {
		logic        load;
		op_type_t    op_type;
		alu_func_t   alu_func;
		word_t       opa;
		logic        opa_valid;
		word_t       opb;
		logic        opb_valid;
		phys_tag_t   dest_tag;
		rob_idx_t    rob_idx;
		logic        cdb_valid;
		phys_tag_t   cdb_tag;
		word_t       cdb_data;
		logic [2:0]  avail;
		rs_full_t    full;
		port_t [2:0] exp;  // Indexed mult, adder, mem
	} row_t;

	logic      clock;
	logic      reset;
	logic      load;
	phys_tag_t dest_tag;
	word_t     opa;
	logic      opa_valid;
	word_t     opb;
	logic      opb_valid;
	op_type_t  op_type;
	alu_func_t alu_func;
	rob_idx_t  rob_idx;
	word_t     cdb_data;
	phys_tag_t cdb_tag;
	logic      cdb_valid;
	logic      mult_available;
	logic      adder_available;
	logic      memory_available;
	word_t     mult_opa, mult_opb;
	word_t     adder_opa, adder_opb;
	word_t     mem_opa, mem_opb;
	phys_tag_t mult_dest_tag, adder_dest_tag, mem_dest_tag;
	rob_idx_t  mult_rob_idx, adder_rob_idx, mem_rob_idx;
	op_type_t  mult_op_type, adder_op_type, mem_op_type;
	alu_func_t mult_alu_func, adder_alu_func, mem_alu_func;
	logic      mult_valid, adder_valid, mem_valid;
	rs_full_t  rs_full;

	port_t     actual [3];
	row_t      rows [MAX_ROWS];
	string     names [MAX_ROWS];
	int        row_count;
	int        checks;
	int        errors;
	int        timeouts;

	rs rs_inst (.*);

	assign actual[0] = {mult_valid, mult_opa, mult_opb, mult_dest_tag, mult_rob_idx,
	                    mult_op_type, mult_alu_func};
	assign actual[1] = {adder_valid, adder_opa, adder_opb, adder_dest_tag, adder_rob_idx,
	                    adder_op_type, adder_alu_func};
	assign actual[2] = {mem_valid, mem_opa, mem_opb, mem_dest_tag, mem_rob_idx,
	                    mem_op_type, mem_alu_func};

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Table helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic port_t idle_port();
		port_t p;
		p          = '0;
		p.alu_func = ALU_DEFAULT;
		return p;
	endfunction

	function automatic string unit_name(input int u);
		case (u)
			0:       return "mult";
			1:       return "adder";
			default: return "mem";
		endcase
	endfunction

	task automatic new_row(input string name, input logic [2:0] avail, input rs_full_t full);
		row_t r;
		r       = '0;
		r.avail = avail;
		r.full  = full;
		for (int u = 0; u < 3; u++) begin
			r.exp[u] = idle_port();
		end
		names[row_count] = name;
		rows[row_count]  = r;
		row_count++;
	endtask

	task automatic dispatch(input op_type_t ot, input alu_func_t af, input word_t a,
	                        input logic av, input word_t b, input logic bv,
	                        input phys_tag_t dt, input rob_idx_t ri);
		int last;
		last                 = row_count - 1;
		rows[last].load      = 1'b1;
		rows[last].op_type   = ot;
		rows[last].alu_func  = af;
		rows[last].opa       = a;
		rows[last].opa_valid = av;  // Low means a holds a tag
		rows[last].opb       = b;
		rows[last].opb_valid = bv;
		rows[last].dest_tag  = dt;
		rows[last].rob_idx   = ri;
	endtask

	task automatic broadcast(input phys_tag_t tag, input word_t data);
		int last;
		last                 = row_count - 1;
		rows[last].cdb_valid = 1'b1;
		rows[last].cdb_tag   = tag;
		rows[last].cdb_data  = data;
	endtask

	task automatic expect_issue(input int u, input word_t a, input word_t b,
	                            input phys_tag_t dt, input rob_idx_t ri,
	                            input op_type_t ot, input alu_func_t af);
		port_t p;
		p.valid                  = 1'b1;
		p.opa                    = a;
		p.opb                    = b;
		p.dest_tag               = dt;
		p.rob_idx                = ri;
		p.op_type                = ot;
		p.alu_func               = af;
		rows[row_count-1].exp[u] = p;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		int k;
		new_row("reset_idle", ALL_UP, MANY_FREE);
		new_row("add_dispatch", ALL_UP, MANY_FREE);
		dispatch(OP_INT, ALU_ADDQ, 64'h11, 1'b1, 64'h22, 1'b1, 6'h01, 5'h01);
		new_row("add_issue", ALL_UP, MANY_FREE);
		expect_issue(1, 64'h11, 64'h22, 6'h01, 5'h01, OP_INT, ALU_ADDQ);
		dispatch(OP_INT, ALU_MULQ, 64'h3, 1'b1, 64'h4, 1'b1, 6'h02, 5'h02);
		new_row("mul_issue", ALL_UP, MANY_FREE);
		expect_issue(0, 64'h3, 64'h4, 6'h02, 5'h02, OP_INT, ALU_MULQ);
		dispatch(OP_LOAD, ALU_ADDQ, 64'h1000, 1'b1, 64'h8, 1'b1, 6'h03, 5'h03);
		new_row("load_issue", ALL_UP, MANY_FREE);
		expect_issue(2, 64'h1000, 64'h8, 6'h03, 5'h03, OP_LOAD, ALU_ADDQ);
		dispatch(OP_STORE, ALU_ADDQ, 64'h2000, 1'b1, 64'h55, 1'b1, 6'h04, 5'h04);
		new_row("store_issue", ALL_UP, MANY_FREE);
		expect_issue(2, 64'h2000, 64'h55, 6'h04, 5'h04, OP_STORE, ALU_ADDQ);
		dispatch(OP_BRANCH, ALU_MULQ, 64'h7, 1'b1, 64'h9, 1'b1, 6'h05, 5'h05);
		new_row("other_class_issue", ALL_UP, MANY_FREE);  // MULQ outside the integer class
		expect_issue(1, 64'h7, 64'h9, 6'h05, 5'h05, OP_BRANCH, ALU_MULQ);
		// Wakeup from the result bus
		new_row("wait_dispatch", ALL_UP, MANY_FREE);
		dispatch(OP_INT, ALU_SUBQ, 64'h21, 1'b0, 64'h30, 1'b1, 6'h06, 5'h06);
		new_row("wrong_tag", ALL_UP, MANY_FREE);
		broadcast(6'h2f, 64'hdead);
		new_row("wake_broadcast", ALL_UP, MANY_FREE);
		broadcast(6'h21, 64'habcd);
		new_row("wake_issue", ALL_UP, MANY_FREE);
		expect_issue(1, 64'habcd, 64'h30, 6'h06, 5'h06, OP_INT, ALU_SUBQ);
		new_row("bypass_dispatch", ALL_UP, MANY_FREE);
		dispatch(OP_INT, ALU_AND, 64'h40, 1'b1, 64'h22, 1'b0, 6'h07, 5'h07);
		broadcast(6'h22, 64'h5a5a);
		new_row("bypass_issue", ALL_UP, MANY_FREE);
		expect_issue(1, 64'h40, 64'h5a5a, 6'h07, 5'h07, OP_INT, ALU_AND);
		// Adder held back, then released in entry order
		new_row("hold_first", ADDER_DOWN, MANY_FREE);
		dispatch(OP_INT, ALU_ADDQ, 64'h100, 1'b1, 64'h1, 1'b1, 6'h08, 5'h08);
		new_row("hold_second", ADDER_DOWN, MANY_FREE);
		dispatch(OP_INT, ALU_ADDQ, 64'h200, 1'b1, 64'h2, 1'b1, 6'h09, 5'h09);
		new_row("hold_wait", ADDER_DOWN, MANY_FREE);
		new_row("release_first", ALL_UP, MANY_FREE);
		expect_issue(1, 64'h100, 64'h1, 6'h08, 5'h08, OP_INT, ALU_ADDQ);
		new_row("release_second", ALL_UP, MANY_FREE);
		expect_issue(1, 64'h200, 64'h2, 6'h09, 5'h09, OP_INT, ALU_ADDQ);
		// Fill all entries with instructions waiting on tag 0x3f
		for (int i = 0; i < `RS_SIZE; i++) begin  // Entry i goes to unit i mod 3
			new_row($sformatf("fill_%0d", i), ALL_UP, (i == `RS_SIZE-1) ? ONE_FREE : MANY_FREE);
			dispatch((i % 3 == 2) ? OP_LOAD : OP_INT, (i % 3 == 0) ? ALU_MULQ : ALU_ADDQ,
			         64'h3f, 1'b0, word_t'(256 + i), 1'b1, phys_tag_t'(32 + i),
			         rob_idx_t'(16 + i));
		end
		new_row("full_broadcast", ALL_UP, NO_FREE);
		broadcast(6'h3f, 64'h77);
		for (int d = 0; d < 3; d++) begin
			new_row($sformatf("drain_%0d", d), ALL_UP, (d == 0) ? NO_FREE : MANY_FREE);
			for (int u = 0; u < 3; u++) begin
				k = 3 * d + u;
				if (k < `RS_SIZE) begin
					expect_issue(u, 64'h77, word_t'(256 + k), phys_tag_t'(32 + k),
					             rob_idx_t'(16 + k), (u == 2) ? OP_LOAD : OP_INT,
					             (u == 0) ? ALU_MULQ : ALU_ADDQ);
				end
			end
		end
		new_row("drained", ALL_UP, MANY_FREE);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drive and check
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_row(input int r);
		load      = rows[r].load;
		op_type   = rows[r].op_type;
		alu_func  = rows[r].alu_func;
		opa       = rows[r].opa;
		opa_valid = rows[r].opa_valid;
		opb       = rows[r].opb;
		opb_valid = rows[r].opb_valid;
		dest_tag  = rows[r].dest_tag;
		rob_idx   = rows[r].rob_idx;
		cdb_valid = rows[r].cdb_valid;
		cdb_tag   = rows[r].cdb_tag;
		cdb_data  = rows[r].cdb_data;
		{memory_available, adder_available, mult_available} = rows[r].avail;
	endtask

	task automatic check_row(input int r);
		for (int u = 0; u < 3; u++) begin
			checks++;
			assert (actual[u] === rows[r].exp[u])
			else begin
				errors++;
				$display("error: %s %s port expected %h actual %h", names[r], unit_name(u),
				         rows[r].exp[u], actual[u]);
			end
		end
		checks++;
		assert (rs_full === rows[r].full)
		else begin
			errors++;
			$display("error: %s rs_full expected %s actual %s", names[r],
			         rows[r].full.name(), rs_full.name());
		end
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while ((mult_valid || adder_valid || mem_valid) && cycles < IDLE_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (mult_valid || adder_valid || mem_valid) begin
			timeouts++;
			$display("station still issuing after %0d cycles of drain", IDLE_LIMIT);
		end
	endtask

	initial begin
		errors    = 0;
		timeouts  = 0;
		checks    = 0;
		row_count = 0;
		reset     = 1'b1;
		build_table();
		apply_row(0);  // First row is quiet, so every input starts idle
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int r = 0; r < row_count; r++) begin
			apply_row(r);
			#SAMPLE_DELAY;
			check_row(r);
			@(negedge clock);
		end
		wait_idle();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rs.f */
+incdir+common
common/rs_pkg.sv
rs/rs_dispatch.sv
rs/rs_entry.sv
rs/rs_issue_select.sv
rs/rs.sv
sim/rs_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the reservation station testbench with Verilator, runs it and
# decides pass or fail from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rs_tb -f rs.f \
	&& ./obj_dir/Vrs_tb | tee /dev/stderr | grep -x "Simulation finished: PASS" > /dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
